// File: verilog/lsq_pkg.sv
// lsq_pkg: queue widths, slot count, access size codes and the address word views
`default_nettype none

package lsq_pkg;

  localparam int ADDR_W = 16;
  localparam int SLOTS = 4;
  localparam int SLOT_W = 2;
  localparam int DATA_W = 64;
  localparam int WDATA_W = 96;

  // 32 banks of 4 bytes, 128 byte line
  localparam int BANK_W = 5;
  localparam int LINE_W = 9;
  localparam int OFF_W = ADDR_W - LINE_W;
  localparam int TAG_W = ADDR_W - BANK_W - 2;

  // access size, 1 << code bytes
  typedef enum logic [1:0] {
    sz_byte = 2'd0,
    sz_half = 2'd1,
    sz_word = 2'd2,
    sz_dword = 2'd3
  } mem_sz_t;

  // one byte address, split by bank or by cache line
  typedef union packed {
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [BANK_W-1:0] bank;
      logic [1:0] low;
    } bank_view;
    struct packed {
      logic [LINE_W-1:0] line;
      logic [OFF_W-1:0] offset;
    } line_view;
  } lsq_addr_u;

endpackage

`default_nettype wire

// File: verilog/wr_format.sv
// wr_format: end bank, byte enables and aligned data for one cache write
`default_nettype none

module wr_format import lsq_pkg::*; (
  input wire lsq_addr_u q_addr,
  input wire mem_sz_t q_sz,
  input wire [DATA_W-1:0] q_data,
  output logic [BANK_W-1:0] wr_bank1,
  output logic [3:0] wr_bgn_ben,
  output logic [3:0] wr_end_ben,
  output logic [WDATA_W-1:0] wr_data
);

  logic [1:0] low;
  logic [7:0] sz_mask;
  logic [3:0] sz_bytes;
  logic [3:0] last_off;
  logic [11:0] span_mask;

  assign low = q_addr.bank_view.low;

  always_comb begin
    case (q_sz)
      sz_byte: sz_mask = 8'h01;
      sz_half: sz_mask = 8'h03;
      sz_word: sz_mask = 8'h0f;
      default: sz_mask = 8'hff;
    endcase
  end

  assign sz_bytes = 4'd1 << q_sz;
  // last byte relative to the first bank, at most 10
  assign last_off = {2'b00, low} + sz_bytes - 4'd1;

  // bytes touched across up to three banks
  assign span_mask = {4'b0000, sz_mask} << low;

  assign wr_bank1 = q_addr.bank_view.bank + BANK_W'(last_off[3:2]);
  assign wr_bgn_ben = span_mask[3:0];

  always_comb begin
    case (last_off[3:2])
      2'd0: wr_end_ben = span_mask[3:0];
      2'd1: wr_end_ben = span_mask[7:4];
      default: wr_end_ben = span_mask[11:8];
    endcase
  end

  assign wr_data = {{(WDATA_W - DATA_W){1'b0}}, q_data} << {low, 3'b000};

endmodule

`default_nettype wire

// File: verilog/store_queue.sv
// store_queue: circular store buffer with commit flags and registered write port stage
`default_nettype none

module store_queue import lsq_pkg::*; #(
  parameter int SQ_DEPTH = 4
) (
  input wire clk,
  input wire rst,
  input wire st_en,
  input wire lsq_addr_u st_addr,
  input wire mem_sz_t st_sz,
  input wire [DATA_W-1:0] st_data,
  input wire sq_commit,
  input wire wr_stall,
  output logic sq_full,
  output logic [SQ_DEPTH-1:0] ent_valid,
  output logic [SQ_DEPTH-1:0][LINE_W-1:0] ent_line,
  output logic wr_en,
  output lsq_addr_u wr_addr,
  output mem_sz_t wr_sz,
  output logic [BANK_W-1:0] wr_bank1,
  output logic [3:0] wr_bgn_ben,
  output logic [3:0] wr_end_ben,
  output logic [WDATA_W-1:0] wr_data
);

  localparam int PTR_W = $clog2(SQ_DEPTH);

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [SQ_DEPTH-1:0] valid;
  logic [SQ_DEPTH-1:0] comm;
  logic [SQ_DEPTH-1:0] valid_nxt;
  logic [SQ_DEPTH-1:0] comm_nxt;
  logic push;
  logic pop;

  lsq_addr_u ent_addr [SQ_DEPTH];
  mem_sz_t ent_sz [SQ_DEPTH];
  logic [DATA_W-1:0] ent_data [SQ_DEPTH];

  // head stage feeding the write port
  logic [DATA_W-1:0] q_data;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(SQ_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign push = st_en & ~sq_full;
  // only a committed head may go to the cache
  assign pop = valid[head] & comm[head] & ~wr_stall;

  always_comb begin
    valid_nxt = valid;
    comm_nxt = comm;
    // entries already in the queue are the retired group's stores
    if (sq_commit) begin
      comm_nxt = comm | valid;
    end
    if (pop) begin
      valid_nxt[head] = 1'b0;
      comm_nxt[head] = 1'b0;
    end
    if (push) begin
      valid_nxt[tail] = 1'b1;
      comm_nxt[tail] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
      valid <= '0;
      comm <= '0;
      sq_full <= 1'b0;
      wr_en <= 1'b0;
    end else begin
      valid <= valid_nxt;
      comm <= comm_nxt;
      sq_full <= &valid_nxt;
      // stall keeps the head in place and the port idle
      wr_en <= pop;
      if (pop) begin
        head <= ptr_inc(head);
      end
      if (push) begin
        tail <= ptr_inc(tail);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      ent_addr[tail] <= st_addr;
      ent_sz[tail] <= st_sz;
      ent_data[tail] <= st_data;
    end
    if (pop) begin
      wr_addr <= ent_addr[head];
      wr_sz <= ent_sz[head];
      q_data <= ent_data[head];
    end
  end

  always_comb begin
    for (int i = 0; i < SQ_DEPTH; i++) begin
      ent_line[i] = ent_addr[i].line_view.line;
    end
  end

  assign ent_valid = valid;

  wr_format fmt0 (
    .q_addr(wr_addr),
    .q_sz(wr_sz),
    .q_data(q_data),
    .wr_bank1(wr_bank1),
    .wr_bgn_ben(wr_bgn_ben),
    .wr_end_ben(wr_end_ben),
    .wr_data(wr_data)
  );

endmodule

`default_nettype wire

// File: verilog/ldq_check.sv
// ldq_check: line match of each load against live store entries
`default_nettype none

module ldq_check import lsq_pkg::*; #(
  parameter int SQ_DEPTH = 4
) (
  input wire clk,
  input wire rst,
  input wire ld_en,
  input wire [SLOT_W-1:0] ld_slot,
  input wire lsq_addr_u ld_addr,
  input wire [SQ_DEPTH-1:0] ent_valid,
  input wire [SQ_DEPTH-1:0][LINE_W-1:0] ent_line,
  output logic ld_done,
  output logic [SLOT_W-1:0] ld_slot_q,
  output logic ld_confl
);

  logic [SQ_DEPTH-1:0] line_hit;
  logic any_hit;

  // same line counts as a conflict, no byte overlap check
  always_comb begin
    for (int i = 0; i < SQ_DEPTH; i++) begin
      line_hit[i] = ent_valid[i] && (ent_line[i] == ld_addr.line_view.line);
    end
  end

  assign any_hit = |line_hit;

  always_ff @(posedge clk) begin
    if (rst) begin
      ld_done <= 1'b0;
    end else begin
      ld_done <= ld_en;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_en) begin
      ld_slot_q <= ld_slot;
      ld_confl <= any_hit;
    end
  end

endmodule

`default_nettype wire

// File: verilog/retire_decide.sv
// retire_decide: open group tracking, retire pulse with per slot result, store commit
`default_nettype none

module retire_decide import lsq_pkg::*; (
  input wire clk,
  input wire rst,
  input wire grp_en,
  input wire [SLOTS-1:0] grp_mask,
  input wire st_en,
  input wire [SLOT_W-1:0] st_slot,
  input wire ld_done,
  input wire [SLOT_W-1:0] ld_slot_q,
  input wire ld_confl,
  output logic grp_ready,
  output logic ret_en,
  output logic [SLOTS-1:0] ret_fine,
  output logic [SLOTS-1:0] ret_ldconfl,
  output logic sq_commit
);

  logic grp_open;
  logic [SLOTS-1:0] mask_q;
  logic [SLOTS-1:0] done_q;
  logic [SLOTS-1:0] confl_q;
  logic grp_done;

  // every slot of the group has finished
  assign grp_done = grp_open && ((done_q & mask_q) == mask_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      grp_open <= 1'b0;
      grp_ready <= 1'b1;
      ret_en <= 1'b0;
      mask_q <= '0;
      done_q <= '0;
      confl_q <= '0;
    end else begin
      ret_en <= grp_done;
      if (grp_en) begin
        grp_open <= 1'b1;
        grp_ready <= 1'b0;
        mask_q <= grp_mask;
        done_q <= '0;
        confl_q <= '0;
      end else begin
        if (grp_done) begin
          grp_open <= 1'b0;
          grp_ready <= 1'b1;
        end
        // a store is done once accepted
        if (st_en) begin
          done_q[st_slot] <= 1'b1;
        end
        if (ld_done) begin
          done_q[ld_slot_q] <= 1'b1;
          confl_q[ld_slot_q] <= ld_confl;
        end
      end
    end
  end

  // masks stay put until the next group start
  assign ret_ldconfl = {SLOTS{ret_en}} & mask_q & confl_q;
  assign ret_fine = {SLOTS{ret_en}} & mask_q & ~confl_q;

  // stores of the retiring group may now drain
  assign sq_commit = ret_en;

endmodule

`default_nettype wire

// File: verilog/lsq_top.sv
// lsq_top: load/store queue top with store queue, load checker and retire logic
`default_nettype none

module lsq_top import lsq_pkg::*; #(
  parameter int SQ_DEPTH = 4
) (
  input wire clk,
  input wire rst,
  // group start
  input wire grp_en,
  input wire [SLOTS-1:0] grp_mask,
  output logic grp_ready,
  // load port
  input wire ld_en,
  input wire [SLOT_W-1:0] ld_slot,
  input wire lsq_addr_u ld_addr,
  // store port
  input wire st_en,
  input wire [SLOT_W-1:0] st_slot,
  input wire lsq_addr_u st_addr,
  input wire mem_sz_t st_sz,
  input wire [DATA_W-1:0] st_data,
  output logic sq_full,
  // retire
  output logic ret_en,
  output logic [SLOTS-1:0] ret_fine,
  output logic [SLOTS-1:0] ret_ldconfl,
  // data cache write port
  input wire wr_stall,
  output logic wr_en,
  output lsq_addr_u wr_addr,
  output mem_sz_t wr_sz,
  output logic [BANK_W-1:0] wr_bank1,
  output logic [3:0] wr_bgn_ben,
  output logic [3:0] wr_end_ben,
  output logic [WDATA_W-1:0] wr_data
);

  logic [SQ_DEPTH-1:0] ent_valid;
  logic [SQ_DEPTH-1:0][LINE_W-1:0] ent_line;
  logic ld_done;
  logic [SLOT_W-1:0] ld_slot_q;
  logic ld_confl;
  logic sq_commit;

  store_queue #(.SQ_DEPTH(SQ_DEPTH)) sq0 (
    .clk(clk),
    .rst(rst),
    .st_en(st_en),
    .st_addr(st_addr),
    .st_sz(st_sz),
    .st_data(st_data),
    .sq_commit(sq_commit),
    .wr_stall(wr_stall),
    .sq_full(sq_full),
    .ent_valid(ent_valid),
    .ent_line(ent_line),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_sz(wr_sz),
    .wr_bank1(wr_bank1),
    .wr_bgn_ben(wr_bgn_ben),
    .wr_end_ben(wr_end_ben),
    .wr_data(wr_data)
  );

  // loads check against stores still in the queue
  ldq_check #(.SQ_DEPTH(SQ_DEPTH)) ldq0 (
    .clk(clk),
    .rst(rst),
    .ld_en(ld_en),
    .ld_slot(ld_slot),
    .ld_addr(ld_addr),
    .ent_valid(ent_valid),
    .ent_line(ent_line),
    .ld_done(ld_done),
    .ld_slot_q(ld_slot_q),
    .ld_confl(ld_confl)
  );

  retire_decide ret0 (
    .clk(clk),
    .rst(rst),
    .grp_en(grp_en),
    .grp_mask(grp_mask),
    .st_en(st_en),
    .st_slot(st_slot),
    .ld_done(ld_done),
    .ld_slot_q(ld_slot_q),
    .ld_confl(ld_confl),
    .grp_ready(grp_ready),
    .ret_en(ret_en),
    .ret_fine(ret_fine),
    .ret_ldconfl(ret_ldconfl),
    .sq_commit(sq_commit)
  );

endmodule

`default_nettype wire

// File: bench/lsq_chk.sv
// lsq_chk: shadow store list and concurrent assertions on retire and write port
`default_nettype none

module lsq_chk import lsq_pkg::*; #(
  parameter int SQ_DEPTH = 4
) (
  input wire clk,
  input wire rst,
  input wire grp_en,
  input wire [SLOTS-1:0] grp_mask,
  input wire grp_ready,
  input wire ld_en,
  input wire [SLOT_W-1:0] ld_slot,
  input wire lsq_addr_u ld_addr,
  input wire st_en,
  input wire lsq_addr_u st_addr,
  input wire mem_sz_t st_sz,
  input wire [DATA_W-1:0] st_data,
  input wire sq_full,
  input wire ret_en,
  input wire [SLOTS-1:0] ret_fine,
  input wire [SLOTS-1:0] ret_ldconfl,
  input wire wr_stall,
  input wire wr_en,
  input wire lsq_addr_u wr_addr,
  input wire mem_sz_t wr_sz,
  input wire [BANK_W-1:0] wr_bank1,
  input wire [3:0] wr_bgn_ben,
  input wire [3:0] wr_end_ben,
  input wire [WDATA_W-1:0] wr_data
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SH_N = 16;

  lsq_addr_u sh_addr [SH_N];
  mem_sz_t sh_sz [SH_N];
  logic [DATA_W-1:0] sh_data [SH_N];
  logic sh_comm [SH_N];
  int sh_cc [SH_N];
  logic [3:0] rd;
  logic [3:0] wr;
  logic [3:0] live_n;
  int cyc;
  logic [SLOTS-1:0] open_mask;
  logic [SLOTS-1:0] exp_confl;
  logic ld_hit;
  logic [BANK_W-1:0] exp_bank1;
  logic [3:0] exp_bgn;
  logic [3:0] exp_end;
  logic [WDATA_W-1:0] exp_data;
  int err_cnt = 0;

  assign live_n = wr - rd;
  assign exp_data = WDATA_W'(sh_data[rd]) << (8 * sh_addr[rd].bank_view.low);

  // a front entry shown on wr_en already left one edge ago
  always_comb begin
    ld_hit = 1'b0;
    for (int k = 0; k < SH_N; k++) begin
      if (4'(k) < live_n && !(k == 0 && wr_en) &&
          sh_addr[rd + 4'(k)].line_view.line == ld_addr.line_view.line) begin
        ld_hit = 1'b1;
      end
    end
  end

  always_comb begin
    logic [3:0] first;
    logic [3:0] last;
    logic [3:0] base;
    first = {2'b00, wr_addr.bank_view.low};
    case (wr_sz)
      sz_byte: last = first;
      sz_half: last = first + 4'd1;
      sz_word: last = first + 4'd3;
      default: last = first + 4'd7;
    endcase
    base = {last[3:2], 2'b00};
    exp_bank1 = wr_addr.bank_view.bank + BANK_W'(last[3:2]);
    for (int b = 0; b < 4; b++) begin
      exp_bgn[b] = (4'(b) >= first) && (4'(b) <= last);
      exp_end[b] = (base + 4'(b) >= first) && (base + 4'(b) <= last);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd <= '0;
      wr <= '0;
      cyc <= 0;
      open_mask <= '0;
      exp_confl <= '0;
    end else begin
      cyc <= cyc + 1;
      if (wr_en) begin
        rd <= rd + 4'd1;
      end
      // retire commits whatever is still pending
      if (ret_en) begin
        for (int k = 0; k < SH_N; k++) begin
          if (4'(k) < live_n && !sh_comm[rd + 4'(k)]) begin
            sh_comm[rd + 4'(k)] <= 1'b1;
            sh_cc[rd + 4'(k)] <= cyc;
          end
        end
      end
      if (st_en) begin
        sh_addr[wr] <= st_addr;
        sh_sz[wr] <= st_sz;
        sh_data[wr] <= st_data;
        sh_comm[wr] <= 1'b0;
        wr <= wr + 4'd1;
      end
      if (grp_en) begin
        open_mask <= grp_mask;
        exp_confl <= '0;
      end
      if (ld_en) begin
        exp_confl[ld_slot] <= ld_hit;
      end
    end
  end

  a_reset: assert property (@(posedge clk) rst |=> !ret_en && !wr_en && grp_ready && !sq_full)
    else begin
      err_cnt = err_cnt + 1;
      $error("Fail at %0t: outputs not idle around reset", $time);
    end

  a_retire: assert property (@(posedge clk) disable iff (rst)
    ret_en |-> (ret_fine & ret_ldconfl) == '0 && (ret_fine | ret_ldconfl) == open_mask &&
      ret_ldconfl == (exp_confl & open_mask) && grp_ready)
    else begin
      err_cnt = err_cnt + 1;
      $error("Fail at %0t: retire masks wrong", $time);
    end

  a_order: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> live_n != 4'd0 && wr_addr == sh_addr[rd] && wr_sz == sh_sz[rd] &&
      wr_data == exp_data && sh_comm[rd] && sh_cc[rd] + 2 <= cyc)
    else begin
      err_cnt = err_cnt + 1;
      $error("Fail at %0t: write port store mismatch", $time);
    end

  a_format: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> wr_bank1 == exp_bank1 && wr_bgn_ben == exp_bgn && wr_end_ben == exp_end)
    else begin
      err_cnt = err_cnt + 1;
      $error("Fail at %0t: bank or byte enables wrong", $time);
    end

  a_stall: assert property (@(posedge clk) disable iff (rst) wr_stall |=> !wr_en)
    else begin
      err_cnt = err_cnt + 1;
      $error("Fail at %0t: write issued after stall", $time);
    end

  // the popped head stays in the shadow list while wr_en shows it
  a_full: assert property (@(posedge clk) disable iff (rst)
    sq_full == (live_n - 4'(wr_en) == 4'(SQ_DEPTH)) && !(sq_full && st_en))
    else begin
      err_cnt = err_cnt + 1;
      $error("Fail at %0t: sq_full wrong or store accepted while full", $time);
    end

endmodule

`default_nettype wire

// File: bench/lsq_tb.sv
// lsq_tb: clock, reset, random load/store groups, timeout and final result
`default_nettype none

module lsq_tb import lsq_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int GROUPS = 200;
  localparam int MAX_CYCLES = GROUPS * 40;
  localparam int SQ_DEPTH = 4;

  logic clk;
  logic rst;
  logic grp_en;
  logic [SLOTS-1:0] grp_mask;
  logic grp_ready;
  logic ld_en;
  logic [SLOT_W-1:0] ld_slot;
  lsq_addr_u ld_addr;
  logic st_en;
  logic [SLOT_W-1:0] st_slot;
  lsq_addr_u st_addr;
  mem_sz_t st_sz;
  logic [DATA_W-1:0] st_data;
  logic sq_full;
  logic ret_en;
  logic [SLOTS-1:0] ret_fine;
  logic [SLOTS-1:0] ret_ldconfl;
  logic wr_stall;
  logic wr_en;
  lsq_addr_u wr_addr;
  mem_sz_t wr_sz;
  logic [BANK_W-1:0] wr_bank1;
  logic [3:0] wr_bgn_ben;
  logic [3:0] wr_end_ben;
  logic [WDATA_W-1:0] wr_data;
  int cycles = 0;

  lsq_top #(.SQ_DEPTH(SQ_DEPTH)) dut0 (.*);

  bind lsq_top lsq_chk #(.SQ_DEPTH(SQ_DEPTH)) chk0 (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // wait for the falling edge, then drop enables and draw a new stall
  task automatic next_cycle();
    @(negedge clk);
    grp_en = 1'b0;
    ld_en = 1'b0;
    st_en = 1'b0;
    wr_stall = ($urandom % 3 == 0);
  endtask

  // few lines so loads hit queued stores
  function automatic lsq_addr_u pick_addr();
    lsq_addr_u a;
    a.line_view.line = {7'd0, 2'($urandom)};
    a.line_view.offset = 7'($urandom);
    return a;
  endfunction

  task automatic run_group();
    logic [SLOTS-1:0] mask;
    mask = SLOTS'($urandom);
    next_cycle();
    while (!grp_ready) begin
      next_cycle();
    end
    grp_en = 1'b1;
    grp_mask = mask;
    for (int s = 0; s < SLOTS; s++) begin
      if (mask[s]) begin
        next_cycle();
        if ($urandom % 2 == 0) begin
          ld_en = 1'b1;
          ld_slot = SLOT_W'(s);
          ld_addr = pick_addr();
        end else begin
          while (sq_full) begin
            next_cycle();
          end
          st_en = 1'b1;
          st_slot = SLOT_W'(s);
          st_addr = pick_addr();
          st_sz = mem_sz_t'(2'($urandom));
          st_data = {$urandom, $urandom};
        end
      end
    end
    next_cycle();
    while (!ret_en) begin
      next_cycle();
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Verification failed");
      $fatal(1, "run hit the cycle limit before all groups retired and all stores drained");
    end
  end

  always @(negedge clk) begin
    if (dut0.chk0.err_cnt != 0) begin
      $display("Verification failed");
      $fatal(1, "an assertion in the checker failed");
    end
  end

  initial begin
    void'($urandom(32'h8fbe039e));
    rst = 1'b1;
    grp_en = 1'b0;
    grp_mask = '0;
    ld_en = 1'b0;
    ld_slot = '0;
    ld_addr = '0;
    st_en = 1'b0;
    st_slot = '0;
    st_addr = '0;
    st_sz = sz_byte;
    st_data = '0;
    wr_stall = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (GROUPS) run_group();
    // every accepted store has to reach the write port
    next_cycle();
    while (dut0.chk0.live_n != 4'd0) begin
      next_cycle();
    end
    if (dut0.chk0.err_cnt == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Verification failed");
      $fatal(1, "assertions in the checker failed");
    end
  end

endmodule

`default_nettype wire

// File: lsq_lite.f
verilog/lsq_pkg.sv
verilog/wr_format.sv
verilog/store_queue.sv
verilog/ldq_check.sv
verilog/retire_decide.sv
verilog/lsq_top.sv
bench/lsq_chk.sv
bench/lsq_tb.sv

// File: Makefile
TOP = lsq_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f lsq_lite.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir
